/* source/ahbMemPkg.sv */
/*
  AHB-Lite memory subsystem package
  Bus widths, the memory map of the on-chip RAM window, the HTRANS,
  HSIZE and HRESP encodings, and the request and reply structs that
  carry a transfer between the top level, the decoder and the RAM
*/

`default_nettype none

package ahbMemPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus and memory geometry
  ////////////////////////////////////////////////////////////////////////////

  // Data bus width and the number of byte lanes on it
  localparam int XLEN  = 32;
  localparam int BYTES = XLEN / 8;

  // Address bus width
  localparam int ADDR_W = 32;

  // The RAM occupies one 4 KiB window starting at its base
  localparam logic [ADDR_W-1:0] RAM_BASE  = 32'h8000_0000;
  localparam logic [ADDR_W-1:0] RAM_RANGE = 32'h0000_0FFF;

  // Word index and byte offset widths inside the window
  localparam int RAM_WORD_W = 10;
  localparam int RAM_OFFSET = 2;

  ////////////////////////////////////////////////////////////////////////////
  // Bus encodings
  ////////////////////////////////////////////////////////////////////////////

  // HTRANS values
  localparam logic [1:0] TRANS_IDLE   = 2'b00;
  localparam logic [1:0] TRANS_BUSY   = 2'b01;
  localparam logic [1:0] TRANS_NONSEQ = 2'b10;
  localparam logic [1:0] TRANS_SEQ    = 2'b11;

  // HSIZE values up to the bus width
  localparam logic [2:0] SIZE_BYTE = 3'b000;
  localparam logic [2:0] SIZE_HALF = 3'b001;
  localparam logic [2:0] SIZE_WORD = 3'b010;

  // HRESP values
  localparam logic RESP_OKAY  = 1'b0;
  localparam logic RESP_ERROR = 1'b1;

  ////////////////////////////////////////////////////////////////////////////
  // Shared types
  ////////////////////////////////////////////////////////////////////////////

  // Address-phase control as the master presents it
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              write;
    logic [1:0]        trans;
    logic [2:0]        size;
  } ahbReqT;

  // One slave's reply during its data phase
  typedef struct packed {
    logic [XLEN-1:0] rdata;
    logic            ready;
    logic            resp;
  } ahbRespT;

  // One write enable per byte lane
  typedef logic [BYTES-1:0] byteMaskT;

endpackage

`default_nettype wire

/* source/byteLaneMask.sv */
/*
  Byte lane mask decoder
  Turns a transfer size and the low address bits into the byte
  write enables of a little-endian 32-bit data bus
*/

`default_nettype none
`timescale 1ns/100ps

module byteLaneMask import ahbMemPkg::*; (
  input  logic [2:0] size,
  input  logic [1:0] addrLow,
  output byteMaskT   mask
);

  always_comb begin
    case (size)
      // A single lane picked by both offset bits
      SIZE_BYTE: mask = byteMaskT'(1) << addrLow;
      // Lower or upper halfword as the aligned offset selects
      SIZE_HALF: mask = addrLow[1] ? byteMaskT'(4'b1100) : byteMaskT'(4'b0011);
      // Whole word
      SIZE_WORD: mask = '1;
      // Sizes wider than the bus are clipped to a full word
      default:   mask = '1;
    endcase
  end

endmodule

`default_nettype wire

/* source/dualPortRam.sv */
/*
  Dual-port block RAM
  One synchronous read port and one byte-maskable write port.
  A read and write to the same word in one cycle returns the
  newly written bytes
*/

`default_nettype none
`timescale 1ns/100ps

module dualPortRam import ahbMemPkg::*; #(
  parameter int addrWidth = RAM_WORD_W
) (
  input  logic                 HCLK,
  input  logic [addrWidth-1:0] rdAddr,
  output logic [XLEN-1:0]      rdData,
  input  logic                 wrEn,
  input  byteMaskT             wrMask,
  input  logic [addrWidth-1:0] wrAddr,
  input  logic [XLEN-1:0]      wrData
);

  // Storage array whose contents are undefined until written
  logic [XLEN-1:0] mem [0:(1 << addrWidth) - 1];

  // Write port updates only the enabled lanes
  always_ff @(posedge HCLK) begin
    for (int b = 0; b < BYTES; b++) begin
      if (wrEn && wrMask[b]) begin
        mem[wrAddr][8*b +: 8] <= wrData[8*b +: 8];
      end
    end
  end

  // Read port with write-first forwarding per byte
  always_ff @(posedge HCLK) begin
    for (int b = 0; b < BYTES; b++) begin
      if (wrEn && wrMask[b] && (wrAddr == rdAddr)) begin
        rdData[8*b +: 8] <= wrData[8*b +: 8];
      end else begin
        rdData[8*b +: 8] <= mem[rdAddr][8*b +: 8];
      end
    end
  end

endmodule

`default_nettype wire

/* source/ahbRam.sv */
/*
  AHB-Lite on-chip RAM slave
  Registers the address phase, holds HREADYOUT low for exactly one
  wait state, returns read data from the block RAM and commits writes
  with a byte mask at the edge that ends the data phase.
  The reply is always OKAY
*/

`default_nettype none
`timescale 1ns/100ps

module ahbRam import ahbMemPkg::*; (
  input  logic            HCLK,
  input  logic            HRESETn,
  input  ahbReqT          req,
  input  logic            sel,
  input  logic            busReady,
  input  logic [XLEN-1:0] HWDATA,
  output ahbRespT         resp
);

  ////////////////////////////////////////////////////////////////////////////
  // Address phase
  ////////////////////////////////////////////////////////////////////////////

  logic                  accept;
  logic [ADDR_W-1:0]     addrReg;
  logic                  writeReg;
  logic [2:0]            sizeReg;

  // Wait state and data-phase tracking
  logic                  busy;
  logic                  phaseEnd;

  // Memory side
  logic [RAM_WORD_W-1:0] wordAddr;
  byteMaskT              wrMask;
  logic                  wrEn;
  logic [XLEN-1:0]       rdData;

  // A transfer is taken when the bus is ready, this slave is selected
  // and the master presents a NONSEQ or SEQ beat
  // Bursts are handled as a string of single transfers
  assign accept = busReady && sel &&
                  ((req.trans == TRANS_NONSEQ) || (req.trans == TRANS_SEQ));

  // Address and size are payload and only change on acceptance
  always_ff @(posedge HCLK) begin
    if (accept) begin
      addrReg <= req.addr;
      sizeReg <= req.size;
    end
  end

  // The accepted direction qualifies the write enable
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      writeReg <= 1'b0;
    end else if (accept) begin
      writeReg <= req.write;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Wait state generator
  ////////////////////////////////////////////////////////////////////////////

  // Busy is high for the single cycle after acceptance
  // While busy the bus is stalled so no new transfer can set it again
  // phaseEnd follows one cycle later and marks the completing cycle
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      busy     <= 1'b0;
      phaseEnd <= 1'b0;
    end else begin
      busy     <= accept;
      phaseEnd <= busy;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Memory access
  ////////////////////////////////////////////////////////////////////////////

  // Word index inside the 4 KiB window
  assign wordAddr = addrReg[RAM_WORD_W+RAM_OFFSET-1:RAM_OFFSET];

  // Lane enables follow the accepted size and byte offset
  byteLaneMask laneMask (
    .size    (sizeReg),
    .addrLow (addrReg[RAM_OFFSET-1:0]),
    .mask    (wrMask)
  );

  // HWDATA is valid through the whole data phase
  // Writing at its final edge lets the master keep a simple timing
  assign wrEn = phaseEnd && writeReg;

  // The read port samples the registered address every cycle
  // so data for a read accepted at E is on the port after E+1
  dualPortRam #(
    .addrWidth (RAM_WORD_W)
  ) memory (
    .HCLK   (HCLK),
    .rdAddr (wordAddr),
    .rdData (rdData),
    .wrEn   (wrEn),
    .wrMask (wrMask),
    .wrAddr (wordAddr),
    .wrData (HWDATA)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reply
  ////////////////////////////////////////////////////////////////////////////

  assign resp.rdata = rdData;
  assign resp.ready = !busy;
  // This slave never signals an error
  assign resp.resp  = RESP_OKAY;

endmodule

`default_nettype wire

/* source/ahbDecoder.sv */
/*
  AHB-Lite address decoder with default slave
  Selects the RAM for addresses in its window, answers every other
  active transfer with the two-cycle ERROR response and multiplexes
  the reply of the data-phase owner back onto the bus
*/

`default_nettype none
`timescale 1ns/100ps

module ahbDecoder import ahbMemPkg::*; (
  input  logic    HCLK,
  input  logic    HRESETn,
  input  ahbReqT  req,
  output logic    ramSel,
  input  ahbRespT ramResp,
  output ahbRespT busResp
);

  // Which slave owns the current data phase
  typedef enum logic [1:0] {OWN_NONE, OWN_RAM, OWN_ERR} ownerT;

  // Default slave progress through its two-cycle ERROR reply
  typedef enum logic [1:0] {ERR_IDLE, ERR_WAIT, ERR_LAST} errStateT;

  logic     ramHit;
  logic     active;
  logic     accept;
  ownerT    owner;
  errStateT errState;

  ////////////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////////////

  assign ramHit = (req.addr >= RAM_BASE) && (req.addr <= RAM_BASE + RAM_RANGE);
  assign ramSel = ramHit;

  // IDLE and BUSY beats need no slave and complete with zero wait
  assign active = (req.trans != TRANS_IDLE) && (req.trans != TRANS_BUSY);

  // The decoder sees the same ready the master does
  assign accept = busResp.ready && active;

  // Owner is only updated at the end of a data phase
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      owner <= OWN_NONE;
    end else if (busResp.ready) begin
      if (!active) begin
        owner <= OWN_NONE;
      end else if (ramHit) begin
        owner <= OWN_RAM;
      end else begin
        owner <= OWN_ERR;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Default slave
  ////////////////////////////////////////////////////////////////////////////

  // ERROR is held for two cycles with ready low in the first and high in the second
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      errState <= ERR_IDLE;
    end else begin
      case (errState)
        // Bus is stalled here so no new transfer can arrive
        ERR_WAIT: errState <= ERR_LAST;
        default:  errState <= (accept && !ramHit) ? ERR_WAIT : ERR_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reply multiplexer
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (owner)
      OWN_RAM: begin
        busResp = ramResp;
      end
      OWN_ERR: begin
        busResp.rdata = '0;
        busResp.ready = (errState == ERR_LAST);
        busResp.resp  = RESP_ERROR;
      end
      default: begin
        // With no data phase in progress the reply is a zero-wait OKAY
        busResp.rdata = '0;
        busResp.ready = 1'b1;
        busResp.resp  = RESP_OKAY;
      end
    endcase
  end

endmodule

`default_nettype wire

/* source/ahbMemSystem.sv */
/*
  AHB-Lite memory subsystem top level
  One slave port in front of the address decoder and the on-chip
  RAM slave. HREADY is generated here and fed back to both slaves
*/

`default_nettype none
`timescale 1ns/100ps

module ahbMemSystem import ahbMemPkg::*; (
  input  logic              HCLK,
  input  logic              HRESETn,
  input  logic [ADDR_W-1:0] HADDR,
  input  logic              HWRITE,
  input  logic [1:0]        HTRANS,
  input  logic [2:0]        HSIZE,
  input  logic [XLEN-1:0]   HWDATA,
  output logic [XLEN-1:0]   HRDATA,
  output logic              HREADY,
  output logic              HRESP
);

  ahbReqT  req;
  ahbRespT ramResp;
  ahbRespT busResp;
  logic    ramSel;

  // Address-phase control bundled for both slaves
  assign req.addr  = HADDR;
  assign req.write = HWRITE;
  assign req.trans = HTRANS;
  assign req.size  = HSIZE;

  ahbDecoder decoder (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .req     (req),
    .ramSel  (ramSel),
    .ramResp (ramResp),
    .busResp (busResp)
  );

  // Bus ready comes back from the multiplexed reply
  ahbRam ram (
    .HCLK     (HCLK),
    .HRESETn  (HRESETn),
    .req      (req),
    .sel      (ramSel),
    .busReady (busResp.ready),
    .HWDATA   (HWDATA),
    .resp     (ramResp)
  );

  assign HRDATA = busResp.rdata;
  assign HREADY = busResp.ready;
  assign HRESP  = busResp.resp;

endmodule

`default_nettype wire

/* bench/ahbMemSystem_props.sv */
/*
  AHB-Lite protocol checks for the memory subsystem port
  Address-phase hold while the bus is stalled, the two-cycle ERROR
  response and the reply seen right after reset
*/

`default_nettype none
`timescale 1ns/100ps

module ahbMemSystem_props import ahbMemPkg::*; (
  input logic              HCLK,
  input logic              HRESETn,
  input logic [ADDR_W-1:0] HADDR,
  input logic [1:0]        HTRANS,
  input logic              HREADY,
  input logic              HRESP
);

  // Number of property failures seen so far
  int failCount = 0;

  // A stalled address phase stays on the bus until it is taken
  holdAddress: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !HREADY |=> ($stable(HTRANS) && $stable(HADDR)))
    else begin
      failCount++;
      $error("address phase changed while HREADY was low");
    end

  // ERROR with ready low is always followed by ERROR with ready high
  errorSecondCycle: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (HRESP == RESP_ERROR && !HREADY) |=> (HRESP == RESP_ERROR && HREADY))
    else begin
      failCount++;
      $error("ERROR response did not complete in its second cycle");
    end

  // The completing ERROR cycle must have been preceded by the stalled one
  errorFirstCycle: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (HRESP == RESP_ERROR && HREADY) |-> $past(HRESP == RESP_ERROR && !HREADY))
    else begin
      failCount++;
      $error("ERROR response completed without its first cycle");
    end

  // On reset release the bus is ready with OKAY
  resetReply: assert property (@(posedge HCLK)
    $rose(HRESETn) |-> (HREADY && HRESP == RESP_OKAY))
    else begin
      failCount++;
      $error("bus not ready with OKAY after reset");
    end

endmodule

bind ahbMemSystem ahbMemSystem_props protocolChecks (
  .HCLK    (HCLK),
  .HRESETn (HRESETn),
  .HADDR   (HADDR),
  .HTRANS  (HTRANS),
  .HREADY  (HREADY),
  .HRESP   (HRESP)
);

`default_nettype wire

/* bench/tbAhbMemSystem.sv */
/*
  Testbench for the AHB-Lite memory subsystem
  A pipelined master runs queues of transfers, a byte-array model
  predicts read data and every reply is checked for its data, its
  response and its number of wait states
*/

`default_nettype none
`timescale 1ns/100ps

module tbAhbMemSystem import ahbMemPkg::*; ();

  localparam int RESET_CYCLES = 16;
  localparam int MAXQ         = 16;
  // Transfers of each test in run order to size the timeout
  localparam int TOTAL_XFERS  = 1 + 32 + 13 + 16 + 16 + 12;
  localparam int CYCLE_LIMIT  = RESET_CYCLES + 2 * TOTAL_XFERS * 3;

  logic              HCLK;
  logic              HRESETn;
  logic [ADDR_W-1:0] HADDR;
  logic              HWRITE;
  logic [1:0]        HTRANS;
  logic [2:0]        HSIZE;
  logic [XLEN-1:0]   HWDATA;
  logic [XLEN-1:0]   HRDATA;
  logic              HREADY;
  logic              HRESP;

  // Transfer queue with the expected read word of each entry
  ahbReqT      qReq [MAXQ];
  logic [31:0] qData [MAXQ];
  logic [31:0] qExp [MAXQ];
  logic        qRam [MAXQ];
  int          qLen = 0;

  // Replies seen for each queued transfer
  ahbRespT     resFinal [MAXQ];
  logic        resFirst [MAXQ];
  int          resWaits [MAXQ];

  // Reference memory with one entry per byte of the RAM window
  logic [7:0]  refMem [0:RAM_RANGE];

  int testErrors = 0;
  int errorCount = 0;
  int checkCount = 0;
  int testsRun = 0;
  int testsFailed = 0;
  int cycles = 0;
  int unsigned seed;

  ahbMemSystem ahbMemSystem_inst (.*);

  initial begin
    HCLK = 1'b0;
    forever #10 HCLK = ~HCLK;
  end

  // Ends a run that stops making progress
  initial begin
    while (cycles < CYCLE_LIMIT) begin
      @(posedge HCLK);
      cycles++;
    end
    $display("Timeout: no result after %0d clock cycles", CYCLE_LIMIT);
    $display("TB FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic isRamAddr(logic [31:0] addr);
    return (addr >= RAM_BASE) && ((addr - RAM_BASE) <= RAM_RANGE);
  endfunction

  // Bytes land little endian on the lane given by their address
  function automatic void modelWrite(logic [31:0] addr, logic [2:0] size, logic [31:0] data);
    int first;
    int count;
    int b;
    first = (size == SIZE_BYTE) ? addr[1:0] : (size == SIZE_HALF) ? {addr[1], 1'b0} : 0;
    count = (size == SIZE_BYTE) ? 1 : (size == SIZE_HALF) ? 2 : 4;
    for (b = first; b < first + count; b++) begin
      refMem[{addr[11:2], 2'b00} + b] = data[8*b +: 8];
    end
  endfunction

  function automatic logic [31:0] modelRead(logic [31:0] addr);
    logic [11:0] base;
    base = {addr[11:2], 2'b00};
    return {refMem[base + 3], refMem[base + 2], refMem[base + 1], refMem[base]};
  endfunction

  function automatic logic [31:0] pickRamWord();
    return RAM_BASE + (($urandom % 1024) << RAM_OFFSET);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Master driver and checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic checkValue(string what, logic [31:0] got, logic [31:0] exp);
    checkCount++;
    assert (got === exp) else begin
      testErrors++;
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // The model is updated in queue order so reads expect earlier writes
  task automatic queueXfer(logic [1:0] trans, logic [31:0] addr, logic write,
                           logic [2:0] size, logic [31:0] data);
    qReq[qLen] = {addr, write, trans, size};
    qData[qLen] = data;
    qRam[qLen] = isRamAddr(addr);
    if (trans != TRANS_IDLE && qRam[qLen] && write) begin
      modelWrite(addr, size, data);
    end
    qExp[qLen] = modelRead(addr);
    resWaits[qLen] = 0;
    resFirst[qLen] = RESP_OKAY;
    qLen++;
  endtask

  // Every active transfer has one wait state and unmapped ones answer ERROR
  task automatic checkReplies();
    int i;
    logic active;
    logic errExp;
    for (i = 0; i < qLen; i++) begin
      active = (qReq[i].trans != TRANS_IDLE);
      errExp = active && !qRam[i];
      checkValue($sformatf("transfer %0d wait states", i), resWaits[i], active ? 1 : 0);
      checkValue($sformatf("transfer %0d HRESP", i), resFinal[i].resp, errExp);
      if (active) begin
        checkValue($sformatf("transfer %0d first HRESP", i), resFirst[i], errExp);
      end
      if (active && qRam[i] && !qReq[i].write) begin
        checkValue($sformatf("transfer %0d read data", i), resFinal[i].rdata, qExp[i]);
      end
    end
    qLen = 0;
  endtask

  // Each address phase overlaps the data phase of the transfer before it
  task automatic issueQueue();
    int addrIdx;
    int dataIdx;
    addrIdx = 0;
    dataIdx = -1;
    while (addrIdx < qLen || dataIdx >= 0) begin
      @(negedge HCLK);
      if (addrIdx < qLen) begin
        {HADDR, HWRITE, HTRANS, HSIZE} = qReq[addrIdx];
      end else begin
        HTRANS = TRANS_IDLE;
      end
      if (dataIdx >= 0) begin
        HWDATA = qData[dataIdx];
      end
      // Outputs only move on the rising edge so they are settled here
      if (HREADY) begin
        if (dataIdx >= 0) begin
          resFinal[dataIdx] = {HRDATA, HREADY, HRESP};
        end
        dataIdx = (addrIdx < qLen) ? addrIdx : -1;
        addrIdx = (addrIdx < qLen) ? addrIdx + 1 : addrIdx;
      end else if (dataIdx >= 0) begin
        resWaits[dataIdx]++;
        resFirst[dataIdx] = HRESP;
      end
    end
    checkReplies();
  endtask

  task automatic finishTest(string name);
    testsRun++;
    if (testErrors == 0) begin
      $display("%s: ok", name);
    end else begin
      testsFailed++;
      $display("%s: %0d errors", name, testErrors);
    end
    errorCount += testErrors;
    testErrors = 0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic resetAndIdle();
    @(negedge HCLK);
    checkValue("HREADY after reset", HREADY, 1'b1);
    checkValue("HRESP after reset", HRESP, RESP_OKAY);
    queueXfer(TRANS_IDLE, RAM_BASE, 1'b0, SIZE_WORD, '0);
    issueQueue();
    finishTest("reset and idle");
  endtask

  task automatic wordWriteRead();
    logic [31:0] addr [16];
    int i;
    for (i = 0; i < 16; i++) begin
      addr[i] = pickRamWord();
      queueXfer(TRANS_NONSEQ, addr[i], 1'b1, SIZE_WORD, $urandom);
    end
    issueQueue();
    for (i = 0; i < 16; i++) begin
      queueXfer(TRANS_NONSEQ, addr[i], 1'b0, SIZE_WORD, '0);
    end
    issueQueue();
    finishTest("word write and read");
  endtask

  // Random data fills all lanes so a wrong mask shows up in the read
  task automatic byteLaneWrites();
    logic [31:0] base;
    int i;
    base = pickRamWord();
    queueXfer(TRANS_NONSEQ, base, 1'b1, SIZE_WORD, $urandom);
    issueQueue();
    for (i = 0; i < 6; i++) begin
      if (i < 4) begin
        queueXfer(TRANS_NONSEQ, base + i, 1'b1, SIZE_BYTE, $urandom);
      end else begin
        queueXfer(TRANS_NONSEQ, base + 2 * (i - 4), 1'b1, SIZE_HALF, $urandom);
      end
      queueXfer(TRANS_NONSEQ, base, 1'b0, SIZE_WORD, '0);
      issueQueue();
    end
    finishTest("byte and halfword lanes");
  endtask

  task automatic pipelinedPairs();
    logic [31:0] addr;
    int i;
    for (i = 0; i < 8; i++) begin
      addr = pickRamWord();
      queueXfer(TRANS_NONSEQ, addr, 1'b1, SIZE_WORD, $urandom);
      queueXfer(TRANS_SEQ, addr, 1'b0, SIZE_WORD, '0);
    end
    issueQueue();
    finishTest("pipelined write and read");
  endtask

  // Unmapped writes share the low address bits of a live RAM word
  task automatic unmappedError();
    logic [31:0] addr;
    int i;
    for (i = 0; i < 4; i++) begin
      addr = pickRamWord();
      queueXfer(TRANS_NONSEQ, addr, 1'b1, SIZE_WORD, $urandom);
      issueQueue();
      queueXfer(TRANS_NONSEQ, addr + 32'h1000, 1'b1, SIZE_WORD, $urandom);
      issueQueue();
      queueXfer(TRANS_NONSEQ, addr & 32'h0000_0FFF, 1'b1, SIZE_HALF, $urandom);
      issueQueue();
      queueXfer(TRANS_NONSEQ, addr, 1'b0, SIZE_WORD, '0);
      issueQueue();
    end
    finishTest("unmapped error");
  endtask

  task automatic errorRecovery();
    logic [31:0] addr;
    int i;
    for (i = 0; i < 4; i++) begin
      addr = pickRamWord();
      queueXfer(TRANS_NONSEQ, addr, 1'b1, SIZE_WORD, $urandom);
      queueXfer(TRANS_NONSEQ, {20'h20000, addr[11:0]}, 1'b0, SIZE_WORD, '0);
      queueXfer(TRANS_NONSEQ, addr, 1'b0, SIZE_WORD, '0);
    end
    issueQueue();
    finishTest("recovery after error");
  endtask

  initial begin
    seed = 32'h2365bed1;
    seed = $urandom(seed);
    HRESETn = 1'b0;
    HADDR = '0;
    HWRITE = 1'b0;
    HTRANS = TRANS_IDLE;
    HSIZE = SIZE_WORD;
    HWDATA = '0;
    repeat (RESET_CYCLES) @(negedge HCLK);
    HRESETn = 1'b1;
    resetAndIdle();
    wordWriteRead();
    byteLaneWrites();
    pipelinedPairs();
    unmappedError();
    errorRecovery();
    errorCount += ahbMemSystem_inst.protocolChecks.failCount;
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d protocol failures",
             testsRun, testsFailed, checkCount, errorCount,
             ahbMemSystem_inst.protocolChecks.failCount);
    if (errorCount == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
source/ahbMemPkg.sv
source/byteLaneMask.sv
source/dualPortRam.sv
source/ahbRam.sv
source/ahbDecoder.sv
source/ahbMemSystem.sv
bench/ahbMemSystem_props.sv
bench/tbAhbMemSystem.sv
